// File: hw/ppu_out_pkg.sv
// ==============================
// Shared definitions of the output pixel path
// Widths, range constants, pipeline latency
// Target resolution and video mode enums
// Pixel, configuration and scanline structs
// ==============================

package ppu_out_pkg;

  localparam int COLOR_W  = 8;
  localparam int POS_W    = 8;
  localparam int SL_STR_W = 8;

  // Limited range is 16 + c * 220 / 256
  localparam int unsigned LIMIT_COEFF  = 220;
  localparam int unsigned LIMIT_OFFSET = 16;

  // Two scanline stages of 2 cycles plus the 3 cycle range stage
  localparam int PIPE_LAT = 7;

  typedef enum logic [2:0] {
    RES_480P  = 3'd0,
    RES_720P  = 3'd1,
    RES_960P  = 3'd2,
    RES_1080P = 3'd3,
    RES_1200P = 3'd4,
    RES_1440P = 3'd5,
    RES_240P  = 3'd6,
    RES_288P  = 3'd7
  } target_res_e;

  typedef enum logic [3:0] {
    MODE_VGA60   = 4'd0,
    MODE_480P60  = 4'd1,
    MODE_720P60  = 4'd2,
    MODE_960P60  = 4'd3,
    MODE_1080P60 = 4'd4,
    MODE_1200P60 = 4'd5,
    MODE_1440P60 = 4'd6,
    MODE_240P60  = 4'd7,
    MODE_576P50  = 4'd8,
    MODE_720P50  = 4'd9,
    MODE_960P50  = 4'd10,
    MODE_1080P50 = 4'd11,
    MODE_1200P50 = 4'd12,
    MODE_1440P50 = 4'd13,
    MODE_288P50  = 4'd14
  } video_mode_e;

  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } rgb_t;

  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
    rgb_t rgb;
  } pixel_t;

  typedef struct packed {
    target_res_e target_res;
    logic        use_vga_480p;
    logic        force60;
    logic        force50;
    logic        low_latency;
    logic        limited_rgb;
    logic        sl_linked_480i;
    // Scanline set for 240p content
    logic        sl240_v_en;
    logic        sl240_h_en;
    logic        sl240_thick;
    logic [3:0]  sl240_str;
    // Scanline set for 480i content
    logic        sl480_v_en;
    logic        sl480_h_en;
    logic        sl480_thick;
    logic [3:0]  sl480_str;
  } ppu_cfg_t;

  typedef struct packed {
    logic palmode;
    logic n64_480i;
  } vinfo_t;

  typedef struct packed {
    logic                v_en;
    logic                h_en;
    logic                thick;
    logic [SL_STR_W-1:0] str;
  } sl_cfg_t;

endpackage

// File: hw/ppu_cfg_decode.sv
// ==============================
// Configuration decoder
// Output video mode from target and 50/60 Hz rules
// Scanline set selection and strength expansion
// Limited RGB flag
// ==============================

module ppu_cfg_decode import ppu_out_pkg::*; (
  input  logic        VCLK_Tx,
  input  logic        nVRST_Tx,
  input  ppu_cfg_t    cfg_i,
  input  vinfo_t      vinfo_i,
  output video_mode_e video_mode_o,
  output sl_cfg_t     sl_cfg_o,
  output logic        limited_rgb_o
);

  video_mode_e mode60;
  video_mode_e mode50;
  video_mode_e mode_nxt;
  logic        force60_ok;
  logic        force50_ok;
  logic        use_480i_set;
  sl_cfg_t     sl_nxt;

  // ==============================
  // Video mode
  // ==============================

  always_comb begin
    case (cfg_i.target_res)
      RES_720P:           mode60 = MODE_720P60;
      RES_960P:           mode60 = MODE_960P60;
      RES_1080P:          mode60 = MODE_1080P60;
      RES_1200P:          mode60 = MODE_1200P60;
      RES_1440P:          mode60 = MODE_1440P60;
      RES_240P, RES_288P: mode60 = MODE_240P60;
      default:            mode60 = cfg_i.use_vga_480p ? MODE_VGA60 : MODE_480P60;
    endcase
  end

  always_comb begin
    case (cfg_i.target_res)
      RES_720P:           mode50 = MODE_720P50;
      RES_960P:           mode50 = MODE_960P50;
      RES_1080P:          mode50 = MODE_1080P50;
      RES_1200P:          mode50 = MODE_1200P50;
      RES_1440P:          mode50 = MODE_1440P50;
      RES_240P, RES_288P: mode50 = MODE_288P50;
      default:            mode50 = MODE_576P50;
    endcase
  end

  // No forcing in low latency mode or against a 240p/288p target
  assign force60_ok = cfg_i.force60 & ~cfg_i.low_latency & (cfg_i.target_res != RES_288P);
  assign force50_ok = cfg_i.force50 & ~cfg_i.low_latency & (cfg_i.target_res != RES_240P);

  assign mode_nxt = force60_ok       ? mode60 :
                    force50_ok       ? mode50 :
                    vinfo_i.palmode  ? mode50 :
                                       mode60;

  // ==============================
  // Scanline settings
  // ==============================

  assign use_480i_set = vinfo_i.n64_480i & ~cfg_i.sl_linked_480i;

  // Strength (s+1)*16-1 is s followed by ones
  always_comb begin
    if (use_480i_set) begin
      sl_nxt.v_en  = cfg_i.sl480_v_en;
      sl_nxt.h_en  = cfg_i.sl480_h_en;
      sl_nxt.thick = cfg_i.sl480_thick;
      sl_nxt.str   = {cfg_i.sl480_str, {(SL_STR_W-4){1'b1}}};
    end else begin
      sl_nxt.v_en  = cfg_i.sl240_v_en;
      sl_nxt.h_en  = cfg_i.sl240_h_en;
      sl_nxt.thick = cfg_i.sl240_thick;
      sl_nxt.str   = {cfg_i.sl240_str, {(SL_STR_W-4){1'b1}}};
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      video_mode_o  <= MODE_480P60;
      sl_cfg_o      <= '0;
      limited_rgb_o <= 1'b0;
    end else begin
      video_mode_o  <= mode_nxt;
      sl_cfg_o      <= sl_nxt;
      limited_rgb_o <= cfg_i.limited_rgb;
    end
  end

endmodule

// File: hw/scanline_stage.sv
// ==============================
// Scanline darkening stage
// Stage one multiplies colour by strength
// Stage two subtracts the scaled colour on scanline pixels
// ==============================

module scanline_stage import ppu_out_pkg::*; #(
  parameter int COLOR_W = ppu_out_pkg::COLOR_W
) (
  input  logic                VCLK_Tx,
  input  logic                nVRST_Tx,
  input  pixel_t              pix_i,
  input  logic                en_i,
  input  logic                thick_i,
  input  logic [SL_STR_W-1:0] str_i,
  input  logic [POS_W-1:0]    rel_pos_i,
  output pixel_t              pix_o
);

  localparam int PROD_W = COLOR_W + SL_STR_W;

  // Thick lines start at half the position range, thin ones at three quarters
  localparam logic [POS_W-1:0] THICK_TH = POS_W'(1 << (POS_W-1));
  localparam logic [POS_W-1:0] THIN_TH  = POS_W'(3 << (POS_W-2));

  logic              on_sl;
  logic              hit_q;
  pixel_t            pix_q;
  logic [PROD_W-1:0] prod_r_q;
  logic [PROD_W-1:0] prod_g_q;
  logic [PROD_W-1:0] prod_b_q;

  assign on_sl = en_i & (rel_pos_i >= (thick_i ? THICK_TH : THIN_TH));

  // Stage one
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pix_q    <= '0;
      hit_q    <= 1'b0;
      prod_r_q <= '0;
      prod_g_q <= '0;
      prod_b_q <= '0;
    end else begin
      pix_q    <= pix_i;
      hit_q    <= on_sl;
      prod_r_q <= pix_i.rgb.r * str_i;
      prod_g_q <= pix_i.rgb.g * str_i;
      prod_b_q <= pix_i.rgb.b * str_i;
    end
  end

  // Stage two, subtrahend never exceeds the colour itself
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pix_o <= '0;
    end else begin
      pix_o <= pix_q;
      if (hit_q) begin
        pix_o.rgb.r <= pix_q.rgb.r - prod_r_q[PROD_W-1 -: COLOR_W];
        pix_o.rgb.g <= pix_q.rgb.g - prod_g_q[PROD_W-1 -: COLOR_W];
        pix_o.rgb.b <= pix_q.rgb.b - prod_b_q[PROD_W-1 -: COLOR_W];
      end
    end
  end

endmodule

// File: hw/rgb_range_out.sv
// ==============================
// Limited RGB range conversion
// Scale by 220/256 with rounding, add offset 16
// Final output registers
// ==============================

module rgb_range_out import ppu_out_pkg::*; #(
  parameter int COLOR_W = ppu_out_pkg::COLOR_W
) (
  input  logic   VCLK_Tx,
  input  logic   nVRST_Tx,
  input  pixel_t pix_i,
  input  logic   limited_rgb_i,
  output pixel_t pix_o
);

  localparam int PROD_W = 2 * COLOR_W;
  localparam logic [COLOR_W-1:0] COEFF  = COLOR_W'(LIMIT_COEFF);
  localparam logic [COLOR_W-1:0] OFFSET = COLOR_W'(LIMIT_OFFSET);

  logic [PROD_W-1:0]  prod_r;
  logic [PROD_W-1:0]  prod_g;
  logic [PROD_W-1:0]  prod_b;
  logic [COLOR_W:0]   scl_r_q;
  logic [COLOR_W:0]   scl_g_q;
  logic [COLOR_W:0]   scl_b_q;
  logic [COLOR_W-1:0] rnd_r_q;
  logic [COLOR_W-1:0] rnd_g_q;
  logic [COLOR_W-1:0] rnd_b_q;
  pixel_t             pix_q1;
  pixel_t             pix_q2;

  assign prod_r = pix_i.rgb.r * COEFF;
  assign prod_g = pix_i.rgb.g * COEFF;
  assign prod_b = pix_i.rgb.b * COEFF;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      scl_r_q <= '0;
      scl_g_q <= '0;
      scl_b_q <= '0;
      rnd_r_q <= '0;
      rnd_g_q <= '0;
      rnd_b_q <= '0;
      pix_q1  <= '0;
      pix_q2  <= '0;
      pix_o   <= '0;
    end else begin
      // Product over 128, one fraction bit kept for rounding
      scl_r_q <= prod_r[PROD_W-1 -: COLOR_W+1];
      scl_g_q <= prod_g[PROD_W-1 -: COLOR_W+1];
      scl_b_q <= prod_b[PROD_W-1 -: COLOR_W+1];
      rnd_r_q <= scl_r_q[COLOR_W:1] + COLOR_W'(scl_r_q[0]);
      rnd_g_q <= scl_g_q[COLOR_W:1] + COLOR_W'(scl_g_q[0]);
      rnd_b_q <= scl_b_q[COLOR_W:1] + COLOR_W'(scl_b_q[0]);
      // Sync, DE and full range colour
      pix_q1 <= pix_i;
      pix_q2 <= pix_q1;
      pix_o  <= pix_q2;
      if (limited_rgb_i) begin
        pix_o.rgb.r <= rnd_r_q + OFFSET;
        pix_o.rgb.g <= rnd_g_q + OFFSET;
        pix_o.rgb.b <= rnd_b_q + OFFSET;
      end
    end
  end

endmodule

// File: hw/ppu_out_top.sv
// ==============================
// Output pixel path top level
// Config decode, vertical and horizontal scanlines
// Range conversion and output registers
// ==============================

module ppu_out_top import ppu_out_pkg::*; #(
  parameter int COLOR_W = ppu_out_pkg::COLOR_W
) (
  input  logic             VCLK_Tx,
  input  logic             nVRST_Tx,
  input  ppu_cfg_t         cfg_i,
  input  vinfo_t           vinfo_i,
  input  pixel_t           pix_i,
  input  logic [POS_W-1:0] vpos_rel_i,
  input  logic [POS_W-1:0] hpos_rel_i,
  output pixel_t           pix_o,
  output video_mode_e      video_mode_o
);

  sl_cfg_t          sl_cfg;
  logic             limited_rgb;
  pixel_t           pix_vert;
  pixel_t           pix_horz;
  logic [POS_W-1:0] vpos_d1;
  logic [POS_W-1:0] vpos_d2;

  ppu_cfg_decode u_cfg_decode (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .cfg_i         (cfg_i),
    .vinfo_i       (vinfo_i),
    .video_mode_o  (video_mode_o),
    .sl_cfg_o      (sl_cfg),
    .limited_rgb_o (limited_rgb)
  );

  scanline_stage #(.COLOR_W(COLOR_W)) u_sl_vert (
    .VCLK_Tx   (VCLK_Tx),
    .nVRST_Tx  (nVRST_Tx),
    .pix_i     (pix_i),
    .en_i      (sl_cfg.v_en),
    .thick_i   (sl_cfg.thick),
    .str_i     (sl_cfg.str),
    .rel_pos_i (hpos_rel_i),
    .pix_o     (pix_vert)
  );

  // Vertical position follows its pixel through the first stage
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vpos_d1 <= '0;
      vpos_d2 <= '0;
    end else begin
      vpos_d1 <= vpos_rel_i;
      vpos_d2 <= vpos_d1;
    end
  end

  scanline_stage #(.COLOR_W(COLOR_W)) u_sl_horz (
    .VCLK_Tx   (VCLK_Tx),
    .nVRST_Tx  (nVRST_Tx),
    .pix_i     (pix_vert),
    .en_i      (sl_cfg.h_en),
    .thick_i   (sl_cfg.thick),
    .str_i     (sl_cfg.str),
    .rel_pos_i (vpos_d2),
    .pix_o     (pix_horz)
  );

  rgb_range_out #(.COLOR_W(COLOR_W)) u_range_out (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .pix_i         (pix_horz),
    .limited_rgb_i (limited_rgb),
    .pix_o         (pix_o)
  );

endmodule

// File: verif/ppu_out_chk.sv
// ==============================
// Concurrent assertions on the output pixel path
// Zero output in reset, DE latency, limited range bounds
// Bound into ppu_out_top
// ==============================

module ppu_out_chk import ppu_out_pkg::*; (
  input logic   VCLK_Tx,
  input logic   nVRST_Tx,
  input pixel_t pix_in_i,
  input pixel_t pix_out_i,
  input logic   limited_rgb_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0;

  a_reset_zero: assert property (@(posedge VCLK_Tx)
    !nVRST_Tx |-> (pix_out_i == '0))
    else begin
      assert_fails++;
      $error("pix_o is not zero during reset");
    end

  // DE leaves the pipeline exactly PIPE_LAT cycles after it enters
  a_de_latency: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    pix_out_i.de == $past(pix_in_i.de, PIPE_LAT))
    else begin
      assert_fails++;
      $error("pix_o.de does not match pix_i.de from %0d cycles earlier", PIPE_LAT);
    end

  // Output register used the flag value of the previous cycle
  a_limited_range: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    ($past(limited_rgb_i) && pix_out_i.de) |->
      (pix_out_i.rgb.r >= 8'd16 && pix_out_i.rgb.r <= 8'd235 &&
       pix_out_i.rgb.g >= 8'd16 && pix_out_i.rgb.g <= 8'd235 &&
       pix_out_i.rgb.b >= 8'd16 && pix_out_i.rgb.b <= 8'd235))
    else begin
      assert_fails++;
      $error("limited range colour outside 16 to 235");
    end

endmodule

bind ppu_out_top ppu_out_chk u_chk (
  .VCLK_Tx       (VCLK_Tx),
  .nVRST_Tx      (nVRST_Tx),
  .pix_in_i      (pix_i),
  .pix_out_i     (pix_o),
  .limited_rgb_i (limited_rgb)
);

// File: verif/ppu_out_monitor.sv
// ==============================
// Output monitor of the pixel path
// Waits for the DE pixel, checks latency, colour and mode
// Keeps pass and fail counts
// ==============================

module ppu_out_monitor import ppu_out_pkg::*; (
  input logic        VCLK_Tx,
  input pixel_t      pix_i,
  input video_mode_e video_mode_i
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_MAX = 20;

  int pass_cnt = 0;
  int fail_cnt = 0;

  // Called on the falling edge one cycle after the test pixel went in
  task automatic check_test(input string name, input pixel_t exp_pix,
                            input video_mode_e exp_mode);
    int   wait_cyc;
    logic ok;
    wait_cyc = 1;
    ok = 1'b1;
    while (!pix_i.de && wait_cyc < WAIT_MAX) begin
      @(negedge VCLK_Tx);
      wait_cyc++;
    end
    if (!pix_i.de) begin
      $display("test %s: no pixel with DE came out within %0d cycles", name, WAIT_MAX);
      ok = 1'b0;
    end else begin
      if (wait_cyc != PIPE_LAT) begin
        $display("test %s: pixel came out after %0d cycles instead of %0d",
                 name, wait_cyc, PIPE_LAT);
        ok = 1'b0;
      end
      if (pix_i !== exp_pix) begin
        $display("[ERROR] %s pix_o expected %h actual %h", name, exp_pix, pix_i);
        ok = 1'b0;
      end
    end
    if (video_mode_i !== exp_mode) begin
      $display("[ERROR] %s video_mode_o expected %0d actual %0d",
               name, exp_mode, video_mode_i);
      ok = 1'b0;
    end
    if (ok) begin
      pass_cnt++;
      $display("test %-18s passed", name);
    end else begin
      fail_cnt++;
      $display("test %-18s failed", name);
    end
  endtask

endmodule

// File: verif/ppu_out_tb.sv
// ==============================
// Testbench of the output pixel path
// Clock, reset, stimulus table with expected values
// Test loop and closing summary
// ==============================

module ppu_out_tb import ppu_out_pkg::*;;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SETTLE_CYC = 4;

  logic             VCLK_Tx;
  logic             nVRST_Tx;
  ppu_cfg_t         cfg_i;
  vinfo_t           vinfo_i;
  pixel_t           pix_i;
  logic [POS_W-1:0] vpos_rel_i;
  logic [POS_W-1:0] hpos_rel_i;
  pixel_t           pix_o;
  video_mode_e      video_mode_o;
  integer           seed;

  // Stimulus table
  string            names[$];
  ppu_cfg_t         cfgs[$];
  vinfo_t           vinfos[$];
  pixel_t           in_pix[$];
  pixel_t           exp_pix[$];
  logic [POS_W-1:0] vposs[$];
  logic [POS_W-1:0] hposs[$];
  video_mode_e      exp_modes[$];

  ppu_out_top #(.COLOR_W(COLOR_W)) dut (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .cfg_i        (cfg_i),
    .vinfo_i      (vinfo_i),
    .pix_i        (pix_i),
    .vpos_rel_i   (vpos_rel_i),
    .hpos_rel_i   (hpos_rel_i),
    .pix_o        (pix_o),
    .video_mode_o (video_mode_o)
  );

  ppu_out_monitor mon (
    .VCLK_Tx      (VCLK_Tx),
    .pix_i        (pix_o),
    .video_mode_i (video_mode_o)
  );

  initial begin
    VCLK_Tx = 1'b0;
    forever #5 VCLK_Tx = ~VCLK_Tx;
  end

  // ==============================
  // Reference rules
  // ==============================

  // 16 + c*220/256, rounded through one fraction bit
  function automatic int limit_colour(int c);
    int sc;
    sc = c * 220 / 128;
    return sc / 2 + sc % 2 + 16;
  endfunction

  function automatic rgb_t expect_rgb(ppu_cfg_t c, vinfo_t vi, rgb_t px,
                                      logic [7:0] vpos, logic [7:0] hpos);
    logic use480;
    logic v_en;
    logic h_en;
    int   str;
    int   th;
    int   ch [3];
    rgb_t res;
    use480 = vi.n64_480i && !c.sl_linked_480i;
    v_en = use480 ? c.sl480_v_en : c.sl240_v_en;
    h_en = use480 ? c.sl480_h_en : c.sl240_h_en;
    th = (use480 ? c.sl480_thick : c.sl240_thick) ? 128 : 192;
    str = ((use480 ? int'(c.sl480_str) : int'(c.sl240_str)) + 1) * 16 - 1;
    ch[0] = int'(px.r);
    ch[1] = int'(px.g);
    ch[2] = int'(px.b);
    for (int k = 0; k < 3; k++) begin
      if (v_en && int'(hpos) >= th)
        ch[k] = ch[k] - ch[k] * str / 256;
      if (h_en && int'(vpos) >= th)
        ch[k] = ch[k] - ch[k] * str / 256;
      if (c.limited_rgb)
        ch[k] = limit_colour(ch[k]);
    end
    res.r = 8'(ch[0]);
    res.g = 8'(ch[1]);
    res.b = 8'(ch[2]);
    return res;
  endfunction

  function automatic rgb_t rand_rgb();
    rgb_t v;
    v = 24'($random(seed));
    return v;
  endfunction

  // flags are {use_vga_480p, force60, force50, low_latency}
  function automatic ppu_cfg_t mode_cfg(target_res_e res, logic [3:0] flags);
    ppu_cfg_t c;
    c = '0;
    c.target_res = res;
    {c.use_vga_480p, c.force60, c.force50, c.low_latency} = flags;
    return c;
  endfunction

  function automatic void add_test(string name, ppu_cfg_t c, vinfo_t vi,
                                   logic [1:0] sync, rgb_t px, logic [7:0] vpos,
                                   logic [7:0] hpos, video_mode_e mode);
    pixel_t p;
    pixel_t e;
    p = {sync, 1'b1, px};
    e = {sync, 1'b1, expect_rgb(c, vi, px, vpos, hpos)};
    names.push_back(name);
    cfgs.push_back(c);
    vinfos.push_back(vi);
    in_pix.push_back(p);
    exp_pix.push_back(e);
    vposs.push_back(vpos);
    hposs.push_back(hpos);
    exp_modes.push_back(mode);
  endfunction

  task automatic build_table();
    ppu_cfg_t c;
    c = mode_cfg(RES_480P, 4'b0000);
    add_test("pass_black", c, 2'b00, 2'b11, 24'h000000, 8'd0, 8'd0, MODE_480P60);
    add_test("pass_random", c, 2'b00, 2'b01, rand_rgb(), 8'd255, 8'd255, MODE_480P60);
    c.limited_rgb = 1'b1;
    add_test("limited_black", c, 2'b00, 2'b10, 24'h000000, 8'd0, 8'd0, MODE_480P60);
    add_test("limited_white", c, 2'b00, 2'b00, 24'hffffff, 8'd0, 8'd0, MODE_480P60);
    add_test("limited_random_a", c, 2'b00, 2'b00, rand_rgb(), 8'd0, 8'd0, MODE_480P60);
    add_test("limited_random_b", c, 2'b00, 2'b01, rand_rgb(), 8'd0, 8'd0, MODE_480P60);
    // Vertical scanlines against thick and thin thresholds
    c = mode_cfg(RES_480P, 4'b0000);
    c.sl240_v_en = 1'b1;
    c.sl240_thick = 1'b1;
    c.sl240_str = 4'd7;
    add_test("vsl_thick_127", c, 2'b00, 2'b00, rand_rgb(), 8'd0, 8'd127, MODE_480P60);
    add_test("vsl_thick_128", c, 2'b00, 2'b00, rand_rgb(), 8'd0, 8'd128, MODE_480P60);
    c.sl240_thick = 1'b0;
    add_test("vsl_thin_191", c, 2'b00, 2'b00, rand_rgb(), 8'd0, 8'd191, MODE_480P60);
    add_test("vsl_thin_192", c, 2'b00, 2'b00, rand_rgb(), 8'd0, 8'd192, MODE_480P60);
    c.sl240_h_en = 1'b1;
    c.sl240_thick = 1'b1;
    c.sl240_str = 4'd9;
    add_test("hvsl_both", c, 2'b00, 2'b00, rand_rgb(), 8'd130, 8'd200, MODE_480P60);
    add_test("hsl_only", c, 2'b00, 2'b00, rand_rgb(), 8'd255, 8'd0, MODE_480P60);
    c.limited_rgb = 1'b1;
    add_test("hvsl_limited", c, 2'b00, 2'b00, rand_rgb(), 8'd140, 8'd150, MODE_480P60);
    // 480i scanline set and its link to the 240p set
    c = mode_cfg(RES_480P, 4'b0000);
    c.sl480_v_en = 1'b1;
    c.sl480_thick = 1'b1;
    c.sl480_str = 4'd3;
    add_test("sl480i_set", c, 2'b01, 2'b00, 24'hffffff, 8'd0, 8'd200, MODE_480P60);
    c.sl_linked_480i = 1'b1;
    add_test("sl480i_linked", c, 2'b01, 2'b00, 24'hffffff, 8'd0, 8'd200, MODE_480P60);
    // Video mode selection
    add_test("mode_pal", mode_cfg(RES_720P, 4'b0000), 2'b10, 2'b00, 24'h123456,
             8'd0, 8'd0, MODE_720P50);
    add_test("mode_force60", mode_cfg(RES_1080P, 4'b0100), 2'b10, 2'b00, 24'h123456,
             8'd0, 8'd0, MODE_1080P60);
    add_test("mode_force50", mode_cfg(RES_960P, 4'b0010), 2'b00, 2'b00, 24'h123456,
             8'd0, 8'd0, MODE_960P50);
    add_test("mode_lowlat", mode_cfg(RES_1200P, 4'b0011), 2'b00, 2'b00, 24'h123456,
             8'd0, 8'd0, MODE_1200P60);
    add_test("mode_f60_288p", mode_cfg(RES_288P, 4'b0100), 2'b10, 2'b00, 24'h123456,
             8'd0, 8'd0, MODE_288P50);
    add_test("mode_f50_240p", mode_cfg(RES_240P, 4'b0010), 2'b00, 2'b00, 24'h123456,
             8'd0, 8'd0, MODE_240P60);
    add_test("mode_vga", mode_cfg(RES_480P, 4'b1000), 2'b00, 2'b00, 24'h123456,
             8'd0, 8'd0, MODE_VGA60);
    add_test("mode_576p", mode_cfg(RES_480P, 4'b1000), 2'b10, 2'b00, 24'h123456,
             8'd0, 8'd0, MODE_576P50);
    add_test("mode_1440p", mode_cfg(RES_1440P, 4'b0001), 2'b10, 2'b00, 24'h123456,
             8'd0, 8'd0, MODE_1440P50);
  endtask

  // ==============================
  // Test sequence
  // ==============================

  initial begin
    nVRST_Tx = 1'b0;
    cfg_i = '0;
    vinfo_i = '0;
    pix_i = '0;
    vpos_rel_i = '0;
    hpos_rel_i = '0;
    seed = 32'ha08c9561;
    build_table();
    repeat (5) @(posedge VCLK_Tx);
    @(negedge VCLK_Tx);
    nVRST_Tx = 1'b1;

    for (int i = 0; i < names.size(); i++) begin
      @(negedge VCLK_Tx);
      cfg_i = cfgs[i];
      vinfo_i = vinfos[i];
      repeat (SETTLE_CYC) @(negedge VCLK_Tx);
      // One DE pixel, idle before and after it
      pix_i = in_pix[i];
      vpos_rel_i = vposs[i];
      hpos_rel_i = hposs[i];
      @(negedge VCLK_Tx);
      pix_i = '0;
      vpos_rel_i = '0;
      hpos_rel_i = '0;
      mon.check_test(names[i], exp_pix[i], exp_modes[i]);
    end

    repeat (2) @(negedge VCLK_Tx);
    $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
             names.size(), mon.pass_cnt, mon.fail_cnt, dut.u_chk.assert_fails);
    if (mon.fail_cnt == 0 && dut.u_chk.assert_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
hw/ppu_out_pkg.sv
hw/ppu_cfg_decode.sv
hw/scanline_stage.sv
hw/rgb_range_out.sv
hw/ppu_out_top.sv
verif/ppu_out_chk.sv
verif/ppu_out_monitor.sv
verif/ppu_out_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the output pixel path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f all.f --top-module ppu_out_tb -o ppu_out_sim

./obj_dir/ppu_out_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
grep -q "ALL TESTS PASSED" sim.log
